/* dcache_pkg.sv */
`default_nettype none

package dcache_pkg;

    // The one-hot way select and the word select depend on this fixed geometry
    localparam int NUM_WAYS   = 4;
    localparam int LINE_BYTES = 64;
    localparam int WORD_SEL_W = 4;
    localparam int LINE_OFF_W = $clog2(LINE_BYTES);  // Index starts above the line offset

    typedef logic [31:0]                   addr_t;
    typedef logic [31:0]                   word_t;
    typedef logic [8*LINE_BYTES-1:0]       line_t;
    typedef logic [NUM_WAYS*8*LINE_BYTES-1:0] set_lines_t;
    typedef logic [NUM_WAYS-1:0]           way_oh_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]   way_idx_t;
    typedef logic [3:0]                    read_type_t;

    // Access size as a byte-enable pattern
    localparam read_type_t RT_BYTE = 4'b0001;
    localparam read_type_t RT_HALF = 4'b0011;
    localparam read_type_t RT_WORD = 4'b1111;

    // Sideband of the CPU port, valid with paddr in the setup phase
    typedef struct packed {
        read_type_t read_type;
        logic       signed_ext;
        logic       uncache;
    } load_attr_t;

    typedef struct packed {
        addr_t      addr;
        load_attr_t attr;
    } load_req_t;

endpackage

`default_nettype wire

/* cache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import dcache_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  addr_t      paddr,
    input  load_attr_t attr,
    output word_t      prdata,
    output logic       pready,
    output logic       pslverr,
    output logic       mem_psel,
    output logic       mem_penable,
    output addr_t      mem_paddr,
    input  line_t      mem_prdata,
    input  logic       mem_pready,
    output logic       lookup_en,
    output addr_t      lookup_addr,
    input  way_oh_t    hit_way,
    input  way_oh_t    victim_way,
    output logic       fill_en,
    output way_oh_t    fill_way,
    output line_t      fill_line,
    output load_req_t  req,
    output word_t      unc_word,
    input  word_t      load_data,
    input  logic       align_err
);

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_SETUP,
        MEM_ACCESS,
        FILL,
        RELOOK,
        RESP
    } state_t;

    state_t state;
    state_t state_nxt;
    logic   setup_phase;
    logic   req_wr;
    logic   req_err;
    logic   lookup_done;

    assign setup_phase = psel && !penable;
    assign req_err     = req_wr || align_err;  // Writes are not supported by this port

    // Errors and cached hits finish in the first access cycle
    assign lookup_done = (state == LOOKUP) &&
                         (req_err || (!req.attr.uncache && hit_way != '0));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:       if (setup_phase) state_nxt = LOOKUP;
            LOOKUP:     state_nxt = lookup_done ? IDLE : MEM_SETUP;
            MEM_SETUP:  state_nxt = MEM_ACCESS;
            MEM_ACCESS: begin
                if (mem_pready) begin
                    state_nxt = req.attr.uncache ? RESP : FILL;  // Uncached data never allocates
                end
            end
            FILL:       state_nxt = RELOOK;
            RELOOK:     state_nxt = RESP;
            RESP:       state_nxt = IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    // Request capture and memory return buffers
    always_ff @(posedge clk) begin
        if (state == IDLE && setup_phase) begin
            req.addr <= paddr;
            req.attr <= attr;
            req_wr   <= pwrite;
        end
        if (state == MEM_ACCESS && mem_pready) begin
            if (req.attr.uncache) begin
                unc_word <= mem_prdata[31:0];
            end else begin
                fill_line <= mem_prdata;
            end
        end
    end

    // Setup phase indexes with the bus address, later states reuse the captured one
    assign lookup_en   = (state == IDLE && setup_phase) || (state == RELOOK);
    assign lookup_addr = (state == IDLE) ? paddr : req.addr;

    assign fill_en  = (state == FILL);
    assign fill_way = victim_way;  // Held by the tag block since the first lookup

    assign mem_psel    = (state == MEM_SETUP) || (state == MEM_ACCESS);
    assign mem_penable = (state == MEM_ACCESS);
    assign mem_paddr   = req.attr.uncache ? {req.addr[31:2], 2'b00}
                                          : {req.addr[31:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

    assign pready  = lookup_done || (state == RESP);
    assign pslverr = (state == LOOKUP) && req_err;
    assign prdata  = (pready && !pslverr) ? load_data : '0;

endmodule

`default_nettype wire

/* tag_lookup.sv */
`timescale 1ns/1ps
`default_nettype none

module tag_lookup import dcache_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    lookup_en,
    input  addr_t   lookup_addr,
    input  logic    fill_en,
    input  way_oh_t fill_way,
    output way_oh_t hit_way,
    output way_oh_t victim_way
);

    localparam int IDX_W = $clog2(SETS);
    localparam int TAG_W = $bits(addr_t) - LINE_OFF_W - IDX_W;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    tag_t     tags   [SETS][NUM_WAYS];
    way_oh_t  valid  [SETS];
    way_idx_t rr_ptr [SETS];  // Next way to replace in each set

    idx_t    idx;
    tag_t    tag;
    way_oh_t tag_match;

    assign idx = lookup_addr[LINE_OFF_W +: IDX_W];
    assign tag = lookup_addr[LINE_OFF_W + IDX_W +: TAG_W];

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            tag_match[w] = valid[idx][w] && (tags[idx][w] == tag);
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (fill_way[w]) tags[idx][w] <= tag;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else if (fill_en) begin
            valid[idx]  <= valid[idx] | fill_way;
            rr_ptr[idx] <= rr_ptr[idx] + 1'b1;
        end
    end

    // Results hold between strobes so the victim survives until the fill
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hit_way    <= '0;
            victim_way <= '0;
        end else if (lookup_en) begin
            hit_way    <= tag_match;
            victim_way <= way_oh_t'(1) << rr_ptr[idx];
        end
    end

endmodule

`default_nettype wire

/* way_data_array.sv */
`timescale 1ns/1ps
`default_nettype none

module way_data_array import dcache_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic       clk,
    input  logic       lookup_en,
    input  addr_t      lookup_addr,
    input  logic       fill_en,
    input  way_oh_t    fill_way,
    input  line_t      fill_line,
    output set_lines_t set_data
);

    localparam int IDX_W  = $clog2(SETS);
    localparam int LINE_W = $bits(line_t);

    typedef logic [IDX_W-1:0] idx_t;

    line_t lines [SETS][NUM_WAYS];
    idx_t  idx;

    assign idx = lookup_addr[LINE_OFF_W +: IDX_W];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (fill_way[w]) lines[idx][w] <= fill_line;  // Only the one-hot way is written
            end
        end
        if (lookup_en) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                set_data[w*LINE_W +: LINE_W] <= lines[idx][w];
            end
        end
    end

endmodule

`default_nettype wire

/* mem_rd_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_rd_ctrl import dcache_pkg::*; (
    input  load_req_t  req,
    input  way_oh_t    hit_way,
    input  set_lines_t set_data,
    input  word_t      unc_word,
    output word_t      load_data,
    output logic       align_err
);

    localparam int LINE_W = $bits(line_t);

    line_t                 way_line;
    word_t                 hit_word;
    logic [WORD_SEL_W-1:0] word_sel;
    logic                  ext;

    assign word_sel = req.addr[2 +: WORD_SEL_W];
    assign ext      = req.attr.signed_ext;

    always_comb begin
        case (hit_way)
            4'b0001: way_line = set_data[0*LINE_W +: LINE_W];
            4'b0010: way_line = set_data[1*LINE_W +: LINE_W];
            4'b0100: way_line = set_data[2*LINE_W +: LINE_W];
            4'b1000: way_line = set_data[3*LINE_W +: LINE_W];
            default: way_line = '0;
        endcase
    end

    // Word i of the line sits in bits 32i upward
    assign hit_word = way_line[{word_sel, 5'b00000} +: 32];

    always_comb begin
        load_data = '0;
        align_err = 1'b0;
        case (req.attr.read_type)
            RT_BYTE: begin
                case (req.addr[1:0])
                    2'd0: load_data = {{24{hit_word[7] & ext}}, hit_word[7:0]};
                    2'd1: load_data = {{24{hit_word[15] & ext}}, hit_word[15:8]};
                    2'd2: load_data = {{24{hit_word[23] & ext}}, hit_word[23:16]};
                    2'd3: load_data = {{24{hit_word[31] & ext}}, hit_word[31:24]};
                endcase
            end
            RT_HALF: begin
                case (req.addr[1:0])
                    2'd0: load_data = {{16{hit_word[15] & ext}}, hit_word[15:0]};
                    2'd2: load_data = {{16{hit_word[31] & ext}}, hit_word[31:16]};
                    default: align_err = 1'b1;  // Half straddles a halfword boundary
                endcase
            end
            RT_WORD: load_data = hit_word;
            default: align_err = 1'b1;
        endcase

        // Uncached data goes back exactly as memory gave it
        if (req.attr.uncache && !align_err) begin
            load_data = unc_word;
        end
    end

endmodule

`default_nettype wire

/* dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int SETS = 16
) (
    input  logic       clk,
    input  logic       arst_n,
    // CPU side APB slave
    input  logic       psel,
    input  logic       penable,
    input  logic       pwrite,
    input  addr_t      paddr,
    input  load_attr_t attr,
    output word_t      prdata,
    output logic       pready,
    output logic       pslverr,
    // Memory side APB master
    output logic       mem_psel,
    output logic       mem_penable,
    output addr_t      mem_paddr,
    input  line_t      mem_prdata,
    input  logic       mem_pready
);

    logic       lookup_en;
    addr_t      lookup_addr;
    way_oh_t    hit_way;
    way_oh_t    victim_way;
    logic       fill_en;
    way_oh_t    fill_way;
    line_t      fill_line;
    set_lines_t set_data;
    load_req_t  req;
    word_t      unc_word;
    word_t      load_data;
    logic       align_err;

    cache_ctrl u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .attr        (attr),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .mem_psel    (mem_psel),
        .mem_penable (mem_penable),
        .mem_paddr   (mem_paddr),
        .mem_prdata  (mem_prdata),
        .mem_pready  (mem_pready),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .fill_line   (fill_line),
        .req         (req),
        .unc_word    (unc_word),
        .load_data   (load_data),
        .align_err   (align_err)
    );

    tag_lookup #(.SETS(SETS)) u_tags (
        .clk         (clk),
        .arst_n      (arst_n),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .hit_way     (hit_way),
        .victim_way  (victim_way)
    );

    way_data_array #(.SETS(SETS)) u_data (
        .clk         (clk),
        .lookup_en   (lookup_en),
        .lookup_addr (lookup_addr),
        .fill_en     (fill_en),
        .fill_way    (fill_way),
        .fill_line   (fill_line),
        .set_data    (set_data)
    );

    mem_rd_ctrl u_rd (
        .req       (req),
        .hit_way   (hit_way),
        .set_data  (set_data),
        .unc_word  (unc_word),
        .load_data (load_data),
        .align_err (align_err)
    );

endmodule

`default_nettype wire

/* dcache_props.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_props import dcache_pkg::*; (
    input logic    clk,
    input logic    arst_n,
    input logic    psel,
    input logic    penable,
    input logic    pready,
    input logic    pslverr,
    input logic    mem_psel,
    input logic    mem_penable,
    input logic    mem_pready,
    input addr_t   mem_paddr,
    input way_oh_t hit_way
);

    int fail_count = 0;

    // Memory request must not move until the slave accepts it
    mem_hold: assert property (@(posedge clk) disable iff (!arst_n)
        mem_psel && !mem_pready |=> mem_psel && $stable(mem_paddr))
        else begin
            $error("memory request changed before mem_pready");
            fail_count++;
        end

    pready_in_access: assert property (@(posedge clk) disable iff (!arst_n)
        pready |-> psel && penable)
        else begin
            $error("pready outside an access phase");
            fail_count++;
        end

    hit_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(hit_way))
        else begin
            $error("hit_way has more than one bit set");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk)
        !arst_n |=> !pready && !pslverr && !mem_psel && !mem_penable)
        else begin
            $error("bus outputs active during reset");
            fail_count++;
        end

endmodule

bind cache_ctrl dcache_props u_props (
    .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pready(pready),
    .pslverr(pslverr), .mem_psel(mem_psel), .mem_penable(mem_penable),
    .mem_pready(mem_pready), .mem_paddr(mem_paddr), .hit_way(hit_way)
);

`default_nettype wire

/* tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int HALF_PERIOD = 2,
    parameter int RST_CYCLES  = 8
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Reset leaves a small gap after the edge so no flop sees it change on a clock
    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_dcache.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dcache import dcache_pkg::*;;

    logic       clk;
    logic       arst_n;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic       pready;
    logic       pslverr;
    logic       mem_psel;
    logic       mem_penable;
    logic       mem_pready;
    addr_t      paddr;
    addr_t      mem_paddr;
    load_attr_t attr;
    word_t      prdata;
    line_t      mem_prdata;
    int         errors = 0;
    int         timeouts = 0;
    int         mem_xfers = 0;

    tb_clkgen clkgen0 (.clk(clk), .arst_n(arst_n));

    dcache_top #(.SETS(16)) dut0 (.*);

    function automatic word_t model_word(addr_t a);
        return {a[31:2], 2'b00} ^ 32'h5A3C0F96;
    endfunction

    // Lane shifted down first, then masked and extended by size
    function automatic word_t expected_load(addr_t a, read_type_t rt, logic sext, logic unc);
        word_t lane;
        if (unc) return model_word(a);
        lane = model_word(a) >> {a[1:0], 3'b000};
        if (rt == RT_BYTE) lane = (sext && lane[7]) ? (lane | 32'hFFFF_FF00) : (lane & 32'hFF);
        if (rt == RT_HALF) lane = (sext && lane[15]) ? (lane | 32'hFFFF_0000) : (lane & 32'hFFFF);
        return lane;
    endfunction

    // Memory slave answers after 0 to 3 wait cycles
    always begin
        int   delay;
        line_t line;
        @(negedge clk);
        if (mem_psel && !mem_penable) begin
            mem_xfers++;
            delay = $urandom_range(3, 0);
            for (int i = 0; i < 16; i++) line[32*i +: 32] = model_word(mem_paddr + 32'(4 * i));
            @(posedge clk);
            #1;
            assert (mem_penable) else begin
                errors++;
                $display("FAILED mem_penable got=%h exp=1", mem_penable);
            end
            repeat (delay) begin
                @(posedge clk);
                #1;
            end
            mem_prdata = line;
            mem_pready = 1'b1;
            @(posedge clk);
            #1 mem_pready = 1'b0;
        end
    end

    task automatic cpu_read(input addr_t a, input read_type_t rt, input logic sext,
                            input logic unc, input logic wr,
                            output word_t data, output logic err, output int xfers);
        int start;
        int cyc;
        start = mem_xfers;
        @(posedge clk);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = a;
        attr.read_type = rt;
        attr.signed_ext = sext;
        attr.uncache = unc;
        @(posedge clk);
        #1 penable = 1'b1;
        cyc = 0;
        @(negedge clk);
        while (!pready && cyc < 40) begin
            @(negedge clk);
            cyc++;
        end
        data = pready ? prdata : '0;
        err = pready ? pslverr : 1'b0;
        xfers = mem_xfers - start;
        if (!pready) begin
            timeouts++;
            $display("No pready within 40 cycles for a read at address %h", a);
        end
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // A negative transfer count skips that check
    task automatic check_load(input addr_t a, input read_type_t rt, input logic sext,
                              input logic unc, input int exp_xfers);
        word_t data;
        word_t exp;
        logic  err;
        int    xf;
        exp = expected_load(a, rt, sext, unc);
        cpu_read(a, rt, sext, unc, 1'b0, data, err, xf);
        assert (!err) else begin
            errors++;
            $display("FAILED pslverr addr=%h got=%h exp=0", a, err);
        end
        assert (data == exp) else begin
            errors++;
            $display("FAILED prdata addr=%h got=%h exp=%h", a, data, exp);
        end
        if (exp_xfers >= 0) assert (xf == exp_xfers) else begin
            errors++;
            $display("FAILED mem_xfers addr=%h got=%h exp=%h", a, xf, exp_xfers);
        end
    endtask

    task automatic confirm_rejected(input addr_t a, input read_type_t rt, input logic wr);
        word_t data;
        logic  err;
        int    xf;
        cpu_read(a, rt, 1'b0, 1'b0, wr, data, err, xf);
        assert (err) else begin
            errors++;
            $display("FAILED pslverr addr=%h got=%h exp=1", a, err);
        end
        assert (data == '0) else begin
            errors++;
            $display("FAILED prdata addr=%h got=%h exp=0", a, data);
        end
        assert (xf == 0) else begin
            errors++;
            $display("FAILED mem_xfers addr=%h got=%h exp=0", a, xf);
        end
    endtask

    initial begin
        logic [31:0] r;
        addr_t a;
        read_type_t rt;
        int n;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        attr = '0;
        mem_prdata = '0;
        mem_pready = 1'b0;
        void'($urandom(84318));
        n = 0;
        while (!arst_n && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (!arst_n) begin
            timeouts++;
            $display("Reset was never released");
        end

        // Fresh tag per load so the first access always misses
        for (int i = 0; i < 12; i++) begin
            r = $urandom();
            a = {22'(i + 1), r[9:0]};
            rt = (r[11:10] == 2'd0) ? RT_BYTE : (r[11:10] == 2'd1) ? RT_HALF : RT_WORD;
            if (rt != RT_BYTE) a[0] = 1'b0;
            if (rt == RT_WORD) a[1] = 1'b0;
            check_load(a, rt, 1'b0, 1'b0, 1);
            check_load(a, rt, 1'b0, 1'b0, 0);
        end

        for (int lane = 0; lane < 4; lane++) begin
            check_load(32'hC000_0100 + 32'(lane), RT_BYTE, 1'b1, 1'b0, -1);
            check_load(32'hC000_0100 + 32'(lane), RT_BYTE, 1'b0, 1'b0, -1);
        end
        for (int h = 0; h < 4; h += 2) begin
            check_load(32'hC000_0100 + 32'(h), RT_HALF, 1'b1, 1'b0, -1);
            check_load(32'hC000_0100 + 32'(h), RT_HALF, 1'b0, 1'b0, -1);
        end

        confirm_rejected(32'hC000_0101, RT_HALF, 1'b0);
        confirm_rejected(32'hC000_0103, RT_HALF, 1'b0);
        confirm_rejected(32'hC000_0100, 4'b0101, 1'b0);
        confirm_rejected(32'hC000_0100, RT_WORD, 1'b1);

        check_load(32'h4000_0209, RT_BYTE, 1'b1, 1'b1, 1);
        check_load(32'h4000_0209, RT_BYTE, 1'b1, 1'b1, 1);
        check_load(32'h4000_0208, RT_WORD, 1'b0, 1'b0, 1);

        // The fifth line filled into set 5 takes the way of the first
        for (int k = 0; k < 5; k++) begin
            check_load(32'h6000_0140 + 32'(k << 10), RT_WORD, 1'b0, 1'b0, 1);
        end
        for (int k = 1; k < 5; k++) begin
            check_load(32'h6000_0140 + 32'(k << 10), RT_WORD, 1'b0, 1'b0, 0);
        end
        check_load(32'h6000_0140, RT_WORD, 1'b0, 1'b0, 1);

        for (int i = 0; i < 60; i++) begin
            r = $urandom();
            a = 32'h8000_0000 | {18'd0, r[13:0]};
            rt = (r[15:14] == 2'd0) ? RT_BYTE : (r[15:14] == 2'd1) ? RT_HALF : RT_WORD;
            if (rt != RT_BYTE) a[0] = 1'b0;
            if (rt == RT_WORD) a[1] = 1'b0;
            check_load(a, rt, r[16], r[19:17] == 3'b000, -1);
        end

        $display("Closing report: %0d check failures, %0d timeouts, %0d property failures",
                 errors, timeouts, dut0.u_ctrl.u_props.fail_count);
        if (errors == 0 && timeouts == 0 && dut0.u_ctrl.u_props.fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
dcache_pkg.sv
cache_ctrl.sv
tag_lookup.sv
way_data_array.sv
mem_rd_ctrl.sv
dcache_top.sv
dcache_props.sv
tb_clkgen.sv
tb_dcache.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -Mdir obj_dir
TOP       = tb_dcache
FILELIST  = sim.f
RUN_FLAGS = +verilator+error+limit+1000
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
